//--- flist.f
spi_pkg.sv
spi_ctrl_if.sv
spi_shift_reg.sv
spi_master.sv
spi_wb_regs.sv
spi_wb_top.sv
spi_slave_model.sv
tb_spi_wb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_spi_wb_top -f flist.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0

//--- tb_spi_wb_top.sv
`default_nettype none

module tb_spi_wb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int         seed         = 32'hb9da;
   localparam int         period       = 40;
   localparam int         drive_delay  = 2;
   localparam int         ack_timeout  = 20;
   localparam int         xfer_timeout = 2000;
   localparam logic [7:0] test_div     = 8'd8;

   logic        clk;
   logic        resetb;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [1:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;
   logic        irq;
   logic        sclk;
   logic        csb;
   logic        mosi;
   logic        miso;
   logic        cpol;
   logic        cpha;
   logic        full_width;
   logic [15:0] reply;
   logic [15:0] slave_rx;
   int          slave_count;
   int          frames;
   int          errors;
   int          tests;
   int          failed_tests;
   int          test_errors;

   spi_wb_top dut0 (
      .clk(clk), .resetb(resetb),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .irq(irq), .sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso)
   );

   spi_slave_model slave0 (
      .clk(clk), .sclk(sclk), .csb(csb), .mosi(mosi),
      .cpol(cpol), .cpha(cpha), .full_width(full_width), .reply(reply),
      .miso(miso), .rx_word(slave_rx), .rx_count(slave_count), .frames(frames)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s did not happen in time", what);
      errors++;
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors != test_errors) begin
         failed_tests++;
         $display("%s: failed", name);
      end else begin
         $display("%s: passed", name);
      end
      test_errors = errors;
   endtask

   task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] data,
                            output logic [31:0] rd);
      int t;
      @(posedge clk);
      #drive_delay;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!wb_ack && t < ack_timeout);
      if (!wb_ack) begin
         report_timeout("Wishbone ack");
      end else begin
         // The registered ack shows up in the second cycle of the access
         check_value("Wishbone ack delay", 2, t);
      end
      rd = wb_dat_r;
      @(posedge clk);
      #drive_delay;
      check_value("Wishbone ack length", 0, wb_ack);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
      logic [31:0] unused;
      wb_access(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
      wb_access(1'b0, adr, '0, data);
   endtask

   task automatic wait_irq();
      int t;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (!irq && t < xfer_timeout);
      if (!irq) report_timeout("interrupt at end of transfer");
   endtask

   task automatic wait_csb_low();
      int t;
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (csb && t < xfer_timeout);
      if (csb) report_timeout("chip select falling");
   endtask

   // Sets the mode in the DUT and in the slave model, then lets sclk settle at cpol
   task automatic configure(input logic pol, input logic pha, input logic full);
      int t;
      cpol       = pol;
      cpha       = pha;
      full_width = full;
      wb_write(spi_pkg::reg_ctrl, {16'h0, test_div, 5'h0, full, pha, pol});
      t = 0;
      do begin
         @(negedge clk);
         t++;
      end while (sclk !== pol && t < xfer_timeout);
      if (sclk !== pol) report_timeout("sclk settling at the idle level");
   endtask

   initial begin
      int          r;
      int          first_frames;
      logic [31:0] rd;
      logic [31:0] val;
      logic [15:0] tx;
      logic [15:0] tx2;
      r            = $urandom(seed);
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      test_errors  = 0;
      resetb       = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      cpol         = 1'b0;
      cpha         = 1'b0;
      full_width   = 1'b1;
      reply        = '0;
      repeat (2) @(posedge clk);
      #drive_delay;
      resetb = 1'b1;

      @(negedge clk);
      check_value("reset csb", 1, csb);
      check_value("reset irq", 0, irq);
      wb_read(spi_pkg::reg_status, rd);
      check_value("reset status", 0, rd);
      wb_read(spi_pkg::reg_rxdata, rd);
      check_value("reset rxdata", 0, rd);
      finish_test("reset values");

      val = $urandom;
      wb_write(spi_pkg::reg_ctrl, val);
      wb_read(spi_pkg::reg_ctrl, rd);
      check_value("ctrl readback", val & 32'h0000_ff07, rd);
      finish_test("control register readback");

      for (int m = 0; m < 4; m++) begin
         configure(m[0], m[1], 1'b1);
         tx    = 16'($urandom);
         reply = 16'($urandom);
         wb_write(spi_pkg::reg_txdata, {16'h0, tx});
         wait_irq();
         check_value("slave word", tx, slave_rx);
         check_value("slave bit count", 16, slave_count);
         wb_read(spi_pkg::reg_rxdata, rd);
         check_value("rxdata", reply, rd);
         wb_read(spi_pkg::reg_status, rd);
         check_value("sclk at rest", cpol, sclk);
         check_value("csb at rest", 1, csb);
         finish_test($sformatf("16-bit transfer, cpol %0d cpha %0d", m[0], m[1]));
      end

      configure(1'b0, 1'b0, 1'b0);
      tx    = 16'($urandom);
      reply = 16'($urandom);
      wb_write(spi_pkg::reg_txdata, {16'h0, tx});
      wait_irq();
      check_value("half slave bit count", 8, slave_count);
      check_value("half slave byte", tx[7:0], slave_rx);
      wb_read(spi_pkg::reg_rxdata, rd);
      check_value("half rxdata byte", reply[7:0], rd[7:0]);
      wb_read(spi_pkg::reg_status, rd);
      finish_test("half-width transfer");

      configure(1'b1, 1'b0, 1'b1);
      wb_write(spi_pkg::reg_txdata, 32'($urandom) & 32'hffff);
      wait_csb_low();
      wb_read(spi_pkg::reg_status, rd);
      check_value("status while busy", 32'h1, rd);
      check_value("csb while busy", 0, csb);
      wait_irq();
      wb_read(spi_pkg::reg_status, rd);
      check_value("status after transfer", 32'h2, rd);
      check_value("irq after status read", 0, irq);
      wb_read(spi_pkg::reg_status, rd);
      check_value("status after clear", 0, rd);
      finish_test("status and interrupt");

      configure(1'b0, 1'b1, 1'b1);
      first_frames = frames;
      tx  = 16'($urandom);
      tx2 = 16'($urandom);
      wb_write(spi_pkg::reg_txdata, {16'h0, tx});
      wait_csb_low();
      wb_write(spi_pkg::reg_txdata, {16'h0, ~tx});
      wait_irq();
      check_value("first word kept", tx, slave_rx);
      check_value("one csb period", first_frames + 1, frames);
      wb_read(spi_pkg::reg_status, rd);
      wb_write(spi_pkg::reg_txdata, {16'h0, tx2});
      wait_irq();
      check_value("fresh word", tx2, slave_rx);
      check_value("second csb period", first_frames + 2, frames);
      wb_read(spi_pkg::reg_status, rd);
      finish_test("write while busy");

      $display("Tests run: %0d, failed: %0d, check errors: %0d", tests, failed_tests, errors);
      if (errors == 0 && failed_tests == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- spi_slave_model.sv
`default_nettype none

module spi_slave_model (
   input  logic        clk,
   input  logic        sclk,
   input  logic        csb,
   input  logic        mosi,
   input  logic        cpol,
   input  logic        cpha,
   input  logic        full_width,
   input  logic [15:0] reply,
   output logic        miso,
   output logic [15:0] rx_word,
   output int          rx_count,
   output int          frames
);
   timeunit 1ns;
   timeprecision 100ps;

   logic        miso_r     = 1'b0;
   logic [15:0] rx_r       = '0;
   int          count_r    = 0;
   int          frames_r   = 0;
   logic        sclk_q     = 1'b1;
   logic        csb_q      = 1'b1;
   logic [15:0] reply_word = '0;
   int          sent       = 0;

   assign miso     = miso_r;
   assign rx_word  = rx_r;
   assign rx_count = count_r;
   assign frames   = frames_r;

   // The SPI lines are looked at on the falling system clock edge, half a cycle
   // away from any change made by the DUT
   always @(negedge clk) begin
      int bits;
      bits = full_width ? 16 : 8;
      if (csb_q && !csb) begin
         frames_r   = frames_r + 1;
         rx_r       = '0;
         count_r    = 0;
         sent       = 0;
         reply_word = full_width ? reply : {reply[7:0], 8'h00};
         // With cpha clear the first bit must be on the wire before the first edge
         if (!cpha) begin
            miso_r = reply_word[15];
            sent   = 1;
         end
      end
      if (!csb && (sclk != sclk_q)) begin
         if (sclk == (cpol ^ !cpha)) begin
            rx_r    = {rx_r[14:0], mosi};
            count_r = count_r + 1;
         end else if (sent < bits) begin
            miso_r = reply_word[15 - sent];
            sent   = sent + 1;
         end
      end
      sclk_q = sclk;
      csb_q  = csb;
   end

endmodule

`default_nettype wire

//--- spi_wb_top.sv
`default_nettype none

module spi_wb_top (
   input  logic                             clk,
   input  logic                             resetb,

   // Wishbone classic slave
   input  logic                             wb_cyc,
   input  logic                             wb_stb,
   input  logic                             wb_we,
   input  logic [spi_pkg::wb_adr_width-1:0] wb_adr,
   input  logic [spi_pkg::wb_dat_width-1:0] wb_dat_w,
   output logic [spi_pkg::wb_dat_width-1:0] wb_dat_r,
   output logic                             wb_ack,

   // Transfer complete interrupt
   output logic                             irq,

   // SPI port
   output logic                             sclk,
   output logic                             csb,
   output logic                             mosi,
   input  logic                             miso
);

   spi_ctrl_if ctrl0 ();

   spi_wb_regs regs0 (
      .clk      (clk),
      .resetb   (resetb),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .irq      (irq),
      .ctrl     (ctrl0)
   );

   spi_master master0 (
      .clk    (clk),
      .resetb (resetb),
      .ctrl   (ctrl0),
      .sclk   (sclk),
      .csb    (csb),
      .mosi   (mosi),
      .miso   (miso)
   );

endmodule

`default_nettype wire

//--- spi_wb_regs.sv
`default_nettype none

module spi_wb_regs (
   input  logic                             clk,
   input  logic                             resetb,
   input  logic                             wb_cyc,
   input  logic                             wb_stb,
   input  logic                             wb_we,
   input  logic [spi_pkg::wb_adr_width-1:0] wb_adr,
   input  logic [spi_pkg::wb_dat_width-1:0] wb_dat_w,
   output logic [spi_pkg::wb_dat_width-1:0] wb_dat_r,
   output logic                             wb_ack,
   output logic                             irq,
   spi_ctrl_if.regs                         ctrl
);

   logic                             access;
   logic                             wr_en;
   logic                             rd_en;
   logic                             done_flag;
   logic [spi_pkg::wb_dat_width-1:0] rd_data;

   // A classic cycle is served in its first cycle, ack follows one cycle later
   assign access = wb_cyc && wb_stb && !wb_ack;
   assign wr_en  = access && wb_we;
   assign rd_en  = access && !wb_we;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;
      end
   end

   // Control fields, frozen while a transfer runs
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         ctrl.cpol        <= 1'b0;
         ctrl.cpha        <= 1'b0;
         ctrl.full_width  <= 1'b1;
         ctrl.clk_divider <= spi_pkg::div_reset;
      end else begin
         if (wr_en && (wb_adr == spi_pkg::reg_ctrl) && !ctrl.busy) begin
            ctrl.cpol        <= wb_dat_w[spi_pkg::ctrl_cpol_bit];
            ctrl.cpha        <= wb_dat_w[spi_pkg::ctrl_cpha_bit];
            ctrl.full_width  <= wb_dat_w[spi_pkg::ctrl_full_bit];
            ctrl.clk_divider <= wb_dat_w[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width];
         end
      end
   end

   // Every transmit write raises go, the engine decides whether to take it
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         ctrl.go <= 1'b0;
      end else begin
         ctrl.go <= wr_en && (wb_adr == spi_pkg::reg_txdata);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en && (wb_adr == spi_pkg::reg_txdata)) begin
         ctrl.tx_data <= wb_dat_w[spi_pkg::data_width-1:0];
      end
   end

   // Sticky done, a new done beats a status read in the same cycle
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         done_flag <= 1'b0;
      end else begin
         if (ctrl.done) begin
            done_flag <= 1'b1;
         end else if (rd_en && (wb_adr == spi_pkg::reg_status)) begin
            done_flag <= 1'b0;
         end
      end
   end

   assign irq = done_flag;

   always_comb begin
      rd_data = '0;
      case (wb_adr)
         spi_pkg::reg_ctrl: begin
            rd_data[spi_pkg::ctrl_cpol_bit] = ctrl.cpol;
            rd_data[spi_pkg::ctrl_cpha_bit] = ctrl.cpha;
            rd_data[spi_pkg::ctrl_full_bit] = ctrl.full_width;
            rd_data[spi_pkg::ctrl_div_lsb +: spi_pkg::div_width] = ctrl.clk_divider;
         end
         spi_pkg::reg_txdata: begin
            rd_data[spi_pkg::data_width-1:0] = ctrl.tx_data;
         end
         spi_pkg::reg_rxdata: begin
            rd_data[spi_pkg::data_width-1:0] = ctrl.rx_data;
         end
         spi_pkg::reg_status: begin
            rd_data[spi_pkg::status_busy_bit] = ctrl.busy;
            rd_data[spi_pkg::status_done_bit] = done_flag;
         end
         default: begin
            rd_data = '0;
         end
      endcase
   end

   // Read data lines up with ack
   always_ff @(posedge clk) begin
      if (rd_en) begin
         wb_dat_r <= rd_data;
      end
   end

endmodule

`default_nettype wire

//--- spi_master.sv
`default_nettype none

module spi_master (
   input  logic       clk,
   input  logic       resetb,
   spi_ctrl_if.master ctrl,
   output logic       sclk,
   output logic       csb,
   output logic       mosi,
   input  logic       miso
);

   spi_pkg::spi_state_e state;

   logic [spi_pkg::div_width-1:0]       clk_count;
   logic [spi_pkg::div_width-1:0]       next_clk_count;
   logic                                pulse;
   logic [spi_pkg::shift_cnt_width-1:0] shift_count;
   logic [spi_pkg::shift_cnt_width-1:0] stop_count;
   logic                                stop;
   logic                                accept;
   logic                                shift_out;
   logic                                shift_in;
   logic [spi_pkg::data_width-1:0]      load_data;
   logic [spi_pkg::data_width-1:0]      rx_word;

   // Pulse train at half the serial clock period
   assign next_clk_count = clk_count + 1'b1;
   assign pulse          = (next_clk_count == (ctrl.clk_divider >> 1));

   assign stop_count = ctrl.full_width ? spi_pkg::stop_full : spi_pkg::stop_half;
   assign stop       = (shift_count >= stop_count);

   // Only a go seen in idle with busy low starts a transfer
   assign accept = ctrl.go && (state == spi_pkg::spi_idle) && !ctrl.busy;

   // A half-width word is moved to the top byte so that it leaves first
   assign load_data = ctrl.full_width ? ctrl.tx_data :
                      {ctrl.tx_data[spi_pkg::half_width-1:0], {spi_pkg::half_width{1'b0}}};

   // MISO is sampled on even half bits, MOSI advances to the next bit on odd ones
   assign shift_in  = pulse && !csb && !shift_count[0];
   assign shift_out = pulse && !csb && shift_count[0];

   spi_shift_reg shifter0 (
      .clk       (clk),
      .resetb    (resetb),
      .load      (accept),
      .load_data (load_data),
      .shift_out (shift_out),
      .shift_in  (shift_in),
      .miso      (miso),
      .mosi      (mosi),
      .rx_data   (rx_word)
   );

   assign ctrl.rx_data = rx_word;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         clk_count <= '0;
      end else begin
         if (pulse) begin
            clk_count <= '0;
         end else begin
            clk_count <= next_clk_count;
         end
      end
   end

   // Transfer FSM with chip select and the shift counter
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         state       <= spi_pkg::spi_idle;
         shift_count <= '0;
         csb         <= 1'b1;
         ctrl.busy   <= 1'b0;
         ctrl.done   <= 1'b0;
      end else begin
         case (state)
            spi_pkg::spi_idle: begin
               csb         <= 1'b1;
               shift_count <= '0;
               ctrl.done   <= 1'b0;
               if (accept) begin
                  state     <= spi_pkg::spi_run;
                  ctrl.busy <= 1'b1;
               end else begin
                  // Busy stays high for this one idle cycle after done
                  ctrl.busy <= 1'b0;
               end
            end
            spi_pkg::spi_run: begin
               if (pulse) begin
                  if (stop) begin
                     csb       <= 1'b1;
                     state     <= spi_pkg::spi_idle;
                     ctrl.done <= 1'b1;
                  end else begin
                     // The first pulse only lowers csb, counting starts after it
                     csb <= 1'b0;
                     if (!csb) begin
                        shift_count <= shift_count + 1'b1;
                     end
                  end
               end
            end
            default: begin
               state <= spi_pkg::spi_idle;
            end
         endcase
      end
   end

   // Serial clock, it rests at cpol outside a transfer
   // With cpha set the leading edge comes on the same pulse that lowers csb
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         sclk <= 1'b1;
      end else begin
         if (pulse) begin
            if ((ctrl.cpha && (state == spi_pkg::spi_run) && !stop) ||
                (!ctrl.cpha && !csb)) begin
               sclk <= !sclk;
            end else begin
               sclk <= ctrl.cpol;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- spi_shift_reg.sv
`default_nettype none

module spi_shift_reg (
   input  logic                           clk,
   input  logic                           resetb,
   input  logic                           load,
   input  logic [spi_pkg::data_width-1:0] load_data,
   input  logic                           shift_out,
   input  logic                           shift_in,
   input  logic                           miso,
   output logic                           mosi,
   output logic [spi_pkg::data_width-1:0] rx_data
);

   logic [spi_pkg::data_width-1:0] tx_word;

   // Transmit side, the MSB is always the bit on the wire
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         tx_word <= '0;
      end else begin
         if (load) begin
            tx_word <= load_data;
         end else if (shift_out) begin
            tx_word <= {tx_word[spi_pkg::data_width-2:0], 1'b0};
         end
      end
   end

   assign mosi = tx_word[spi_pkg::data_width-1];

   // Receive side fills from the LSB, so the first bit in ends up as the MSB
   // A load clears it so a half-width reply has a clean upper byte
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rx_data <= '0;
      end else begin
         if (load) begin
            rx_data <= '0;
         end else if (shift_in) begin
            rx_data <= {rx_data[spi_pkg::data_width-2:0], miso};
         end
      end
   end

endmodule

`default_nettype wire

//--- spi_ctrl_if.sv
`default_nettype none

interface spi_ctrl_if;

   // Configuration, held steady by the register block while busy is high
   logic                              cpol;
   logic                              cpha;
   logic                              full_width;
   logic [spi_pkg::div_width-1:0]     clk_divider;

   // Start request and the word to send
   logic                              go;
   logic [spi_pkg::data_width-1:0]    tx_data;

   // Engine results
   logic [spi_pkg::data_width-1:0]    rx_data;
   logic                              busy;
   logic                              done;

   modport regs (
      output cpol, cpha, full_width, clk_divider,
      output go, tx_data,
      input  rx_data, busy, done
   );

   modport master (
      input  cpol, cpha, full_width, clk_divider,
      input  go, tx_data,
      output rx_data, busy, done
   );

endinterface

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

   // Transfer widths
   localparam int data_width = 16;
   localparam int half_width = 8;
   localparam int div_width  = 8;

   // Wishbone bus geometry
   localparam int wb_adr_width = 2;
   localparam int wb_dat_width = 32;

   // The shift counter counts half bits, two per transferred bit
   localparam int shift_cnt_width = $clog2(2 * data_width);

   // Last half-bit count of a transfer, full and half width
   localparam logic [shift_cnt_width-1:0] stop_full = shift_cnt_width'(2 * data_width - 1);
   localparam logic [shift_cnt_width-1:0] stop_half = shift_cnt_width'(2 * half_width - 1);

   // Register map, word addresses
   localparam logic [wb_adr_width-1:0] reg_ctrl   = wb_adr_width'(0);
   localparam logic [wb_adr_width-1:0] reg_txdata = wb_adr_width'(1);
   localparam logic [wb_adr_width-1:0] reg_rxdata = wb_adr_width'(2);
   localparam logic [wb_adr_width-1:0] reg_status = wb_adr_width'(3);

   // Control register fields
   localparam int ctrl_cpol_bit = 0;
   localparam int ctrl_cpha_bit = 1;
   localparam int ctrl_full_bit = 2;
   localparam int ctrl_div_lsb  = 8;

   // Status register fields
   localparam int status_busy_bit = 0;
   localparam int status_done_bit = 1;

   // Divider value after reset
   localparam logic [div_width-1:0] div_reset = div_width'(4);

   // Engine states
   typedef enum logic {
      spi_idle,
      spi_run
   } spi_state_e;

endpackage

`default_nettype wire
